/* Makefile */
# Verilator build and run for the control unit testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := control_unit_tb
RTL_TOP   := control_unit
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+include
hdl/cpu_ctrl_pkg.sv
hdl/opcode_decoder.sv
hdl/ctrl_sequencer.sv
hdl/mem_addr_gen.sv
hdl/control_unit.sv
tests/control_unit_tb.sv

/* hdl/control_unit.sv */
/*
 * CPU control unit top
 * Ties together the opcode decoder, sequencer and address generator
 */
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  wire                             clk,
    input  wire                             reset,
    input  wire [cpu_ctrl_pkg::DATA_W-1:0]  flags,
    input  wire                             alu_done,
    input  wire [cpu_ctrl_pkg::DATA_W-1:0]  data_bus,
    input  wire [cpu_ctrl_pkg::ADDR_W-1:0]  pc_current,
    output logic                            acc_write,
    output logic                            x_write,
    output logic                            y_write,
    output logic                            pc_inc,
    output logic                            pc_load,
    output logic                            mem_read,
    output logic                            mem_write,
    output cpu_ctrl_pkg::alu_op_t           alu_operation,
    output logic                            alu_start,
    output logic [cpu_ctrl_pkg::ADDR_W-1:0] mem_addr,
    output logic [cpu_ctrl_pkg::ADDR_W-1:0] pc_direct,
    output logic                            done
);

    import cpu_ctrl_pkg::*;

    opcode_t      opcode;
    instr_class_t instr_class;
    alu_op_t      alu_op;
    dest_t        dest;
    cond_t        cond;
    addr_sel_t    addr_sel;

    opcode_decoder u_decoder (
        .opcode      (opcode),
        .instr_class (instr_class),
        .alu_op      (alu_op),
        .dest        (dest),
        .cond        (cond)
    );

    ctrl_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .data_bus      (data_bus),
        .flags         (flags),
        .alu_done      (alu_done),
        .instr_class   (instr_class),
        .alu_op        (alu_op),
        .dest          (dest),
        .cond          (cond),
        .opcode        (opcode),
        .addr_sel      (addr_sel),
        .acc_write     (acc_write),
        .x_write       (x_write),
        .y_write       (y_write),
        .pc_inc        (pc_inc),
        .pc_load       (pc_load),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .alu_start     (alu_start),
        .done          (done),
        .alu_operation (alu_operation)
    );

    mem_addr_gen u_addr_gen (
        .clk        (clk),
        .reset      (reset),
        .addr_sel   (addr_sel),
        .pc_current (pc_current),
        .data_bus   (data_bus),
        .mem_addr   (mem_addr),
        .pc_direct  (pc_direct)
    );

endmodule

`default_nettype wire

/* hdl/cpu_ctrl_pkg.sv */
/*
 * CPU control unit package
 * Opcodes, ALU operation codes, flag positions and decode enums
 */
`default_nettype none

package cpu_ctrl_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // ==============================
    // Opcodes
    // ==============================
    typedef logic [DATA_W-1:0] opcode_t;

    localparam opcode_t OPC_NOP     = 8'h00;
    localparam opcode_t OPC_LDA_IMM = 8'h01;
    localparam opcode_t OPC_LDA_DIR = 8'h02;
    localparam opcode_t OPC_STA_DIR = 8'h03;
    localparam opcode_t OPC_LDX_IMM = 8'h04;
    localparam opcode_t OPC_LDY_IMM = 8'h05;

    localparam opcode_t OPC_ADD_IMM = 8'h10;
    localparam opcode_t OPC_SUB_IMM = 8'h11;
    localparam opcode_t OPC_MUL     = 8'h12;
    localparam opcode_t OPC_DIV     = 8'h13;
    localparam opcode_t OPC_INC     = 8'h14;
    localparam opcode_t OPC_DEC     = 8'h15;

    localparam opcode_t OPC_AND_IMM = 8'h20;
    localparam opcode_t OPC_OR_IMM  = 8'h21;
    localparam opcode_t OPC_XOR_IMM = 8'h22;
    localparam opcode_t OPC_NOT     = 8'h23;

    localparam opcode_t OPC_SHL     = 8'h30;
    localparam opcode_t OPC_SHR     = 8'h31;
    localparam opcode_t OPC_ROL     = 8'h32;
    localparam opcode_t OPC_ROR     = 8'h33;

    localparam opcode_t OPC_CMP_IMM = 8'h40;

    localparam opcode_t OPC_BEQ     = 8'h50;
    localparam opcode_t OPC_BNE     = 8'h51;
    localparam opcode_t OPC_BMI     = 8'h52;
    localparam opcode_t OPC_BPL     = 8'h53;
    localparam opcode_t OPC_BCS     = 8'h54;
    localparam opcode_t OPC_BCC     = 8'h55;
    localparam opcode_t OPC_BRA     = 8'h56;
    localparam opcode_t OPC_JMP     = 8'h60;

    // ==============================
    // ALU operations
    // ==============================
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0, ALU_SUB = 4'h1, ALU_MUL = 4'h2, ALU_DIV = 4'h3,
        ALU_AND = 4'h4, ALU_OR  = 4'h5, ALU_XOR = 4'h6, ALU_NOT = 4'h7,
        ALU_SHL = 4'h8, ALU_SHR = 4'h9, ALU_ROL = 4'hA, ALU_ROR = 4'hB,
        ALU_INC = 4'hC, ALU_DEC = 4'hD, ALU_CMP = 4'hE
    } alu_op_t;

    // Bit positions in the flags word
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;

    // ==============================
    // Decode and sequencing enums
    // ==============================
    typedef enum logic [2:0] {
        CL_NOP, CL_LOAD_IMM, CL_LOAD_DIR, CL_STORE_DIR,
        CL_ALU_IMM, CL_ALU_IMPL, CL_BRANCH, CL_JUMP
    } instr_class_t;

    typedef enum logic [1:0] {DEST_NONE, DEST_ACC, DEST_X, DEST_Y} dest_t;

    typedef enum logic [2:0] {
        COND_ALWAYS, COND_Z, COND_NZ, COND_N, COND_NN, COND_C, COND_NC
    } cond_t;

    typedef enum logic [2:0] {
        ASEL_HOLD, ASEL_PC, ASEL_PC_NEXT, ASEL_OPERAND, ASEL_BRANCH, ASEL_JUMP
    } addr_sel_t;

endpackage

`default_nettype wire

/* hdl/ctrl_sequencer.sv */
/*
 * Control sequencer
 * Fetch, decode and execute FSM issuing register, memory, PC and ALU strobes
 */
`timescale 1ns/10ps
`default_nettype none

module ctrl_sequencer (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  [cpu_ctrl_pkg::DATA_W-1:0]  data_bus,
    input  wire  [cpu_ctrl_pkg::DATA_W-1:0]  flags,
    input  wire                              alu_done,
    input  wire  cpu_ctrl_pkg::instr_class_t instr_class,
    input  wire  cpu_ctrl_pkg::alu_op_t      alu_op,
    input  wire  cpu_ctrl_pkg::dest_t        dest,
    input  wire  cpu_ctrl_pkg::cond_t        cond,
    output cpu_ctrl_pkg::opcode_t            opcode,
    output cpu_ctrl_pkg::addr_sel_t          addr_sel,
    output logic                             acc_write,
    output logic                             x_write,
    output logic                             y_write,
    output logic                             pc_inc,
    output logic                             pc_load,
    output logic                             mem_read,
    output logic                             mem_write,
    output logic                             alu_start,
    output logic                             done,
    output cpu_ctrl_pkg::alu_op_t            alu_operation
);

    import cpu_ctrl_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_DECODE, S_OPERAND,
        S_DIR_READ, S_STORE, S_ALU_WAIT, S_PC_LOAD
    } state_t;

    state_t  state, state_nxt;
    opcode_t opcode_q;
    logic    dir_data;     // Second cycle of the direct read
    logic    wr_en;
    logic    cond_ok;

    // Opcode byte sits on the bus during DECODE and is held after that
    assign opcode        = (state == S_DECODE) ? data_bus : opcode_q;
    assign alu_operation = alu_op;

    always_comb begin
        case (cond)
            COND_Z:  cond_ok = flags[FLAG_Z];
            COND_NZ: cond_ok = !flags[FLAG_Z];
            COND_N:  cond_ok = flags[FLAG_N];
            COND_NN: cond_ok = !flags[FLAG_N];
            COND_C:  cond_ok = flags[FLAG_C];
            COND_NC: cond_ok = !flags[FLAG_C];
            default: cond_ok = 1'b1;
        endcase
    end

    // ==============================
    // Next state and strobes
    // ==============================
    always_comb begin
        state_nxt = state;
        addr_sel  = ASEL_HOLD;
        wr_en     = 1'b0;
        pc_inc    = 1'b0;
        pc_load   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        alu_start = 1'b0;
        done      = 1'b0;
        case (state)
            S_IDLE: begin
                addr_sel  = ASEL_PC;
                state_nxt = S_FETCH;
            end
            S_FETCH: begin
                mem_read  = 1'b1;
                pc_inc    = 1'b1;
                addr_sel  = ASEL_PC_NEXT;     // Operand address for the byte after the opcode
                state_nxt = S_DECODE;
            end
            S_DECODE: begin
                case (instr_class)
                    CL_NOP: begin
                        done      = 1'b1;
                        state_nxt = S_IDLE;
                    end
                    CL_ALU_IMPL: begin
                        alu_start = 1'b1;
                        state_nxt = S_ALU_WAIT;
                    end
                    default: begin
                        mem_read  = 1'b1;
                        pc_inc    = 1'b1;
                        state_nxt = S_OPERAND;
                    end
                endcase
            end
            S_OPERAND: begin
                state_nxt = S_IDLE;
                case (instr_class)
                    CL_LOAD_IMM: begin
                        wr_en = 1'b1;
                        done  = 1'b1;
                    end
                    CL_LOAD_DIR: begin
                        addr_sel  = ASEL_OPERAND;
                        state_nxt = S_DIR_READ;
                    end
                    CL_STORE_DIR: begin
                        addr_sel  = ASEL_OPERAND;
                        state_nxt = S_STORE;
                    end
                    CL_ALU_IMM: begin
                        alu_start = 1'b1;
                        state_nxt = S_ALU_WAIT;
                    end
                    CL_BRANCH: begin
                        if (cond_ok) begin
                            addr_sel  = ASEL_BRANCH;
                            state_nxt = S_PC_LOAD;
                        end else begin
                            done = 1'b1;           // Not taken and offset already consumed
                        end
                    end
                    CL_JUMP: begin
                        addr_sel  = ASEL_JUMP;
                        state_nxt = S_PC_LOAD;
                    end
                    default: done = 1'b1;
                endcase
            end
            S_DIR_READ: begin
                if (!dir_data) begin
                    mem_read = 1'b1;
                end else begin
                    wr_en     = 1'b1;
                    done      = 1'b1;
                    state_nxt = S_IDLE;
                end
            end
            S_STORE: begin
                mem_write = 1'b1;
                done      = 1'b1;
                state_nxt = S_IDLE;
            end
            S_ALU_WAIT: begin
                if (alu_done) begin
                    wr_en     = 1'b1;              // CMP decodes to DEST_NONE
                    done      = 1'b1;
                    state_nxt = S_IDLE;
                end
            end
            S_PC_LOAD: begin
                pc_load   = 1'b1;
                done      = 1'b1;
                state_nxt = S_IDLE;
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    assign acc_write = wr_en && (dest == DEST_ACC);
    assign x_write   = wr_en && (dest == DEST_X);
    assign y_write   = wr_en && (dest == DEST_Y);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= S_IDLE;
            opcode_q <= OPC_NOP;
            dir_data <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == S_DECODE) begin
                opcode_q <= data_bus;
            end
            if (state == S_DIR_READ) begin
                dir_data <= !dir_data;
            end
        end
    end

    // ==============================
    // Checks
    // ==============================
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write));

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done);

    a_load_no_mem: assert property (@(posedge clk) disable iff (reset)
        pc_load |-> !(mem_read || mem_write));

endmodule

`default_nettype wire

/* hdl/mem_addr_gen.sv */
/*
 * Memory address generator
 * Holds the memory address register and forms branch and jump targets
 */
`timescale 1ns/10ps
`default_nettype none

module mem_addr_gen (
    input  wire                             clk,
    input  wire                             reset,
    input  wire cpu_ctrl_pkg::addr_sel_t    addr_sel,
    input  wire [cpu_ctrl_pkg::ADDR_W-1:0]  pc_current,
    input  wire [cpu_ctrl_pkg::DATA_W-1:0]  data_bus,
    output logic [cpu_ctrl_pkg::ADDR_W-1:0] mem_addr,
    output logic [cpu_ctrl_pkg::ADDR_W-1:0] pc_direct
);

    import cpu_ctrl_pkg::*;

    logic [ADDR_W-1:0] zero_ext;
    logic [ADDR_W-1:0] sign_ext;

    assign zero_ext = {{(ADDR_W-DATA_W){1'b0}}, data_bus};
    assign sign_ext = {{(ADDR_W-DATA_W){data_bus[DATA_W-1]}}, data_bus};

    // ==============================
    // Address and target registers
    // ==============================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_addr  <= '0;
            pc_direct <= '0;
        end else begin
            case (addr_sel)
                ASEL_PC:      mem_addr  <= pc_current;
                ASEL_PC_NEXT: mem_addr  <= pc_current + ADDR_W'(1);
                ASEL_OPERAND: mem_addr  <= zero_ext;            // Page zero
                // PC already points past the offset byte here
                ASEL_BRANCH:  pc_direct <= pc_current + sign_ext;
                ASEL_JUMP:    pc_direct <= zero_ext;
                default:      mem_addr  <= mem_addr;
            endcase
        end
    end

    a_sel_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(addr_sel));

endmodule

`default_nettype wire

/* hdl/opcode_decoder.sv */
/*
 * Opcode decoder
 * Maps an opcode to instruction class, ALU operation, destination
 * register and branch condition. Unknown opcodes decode as NOP
 */
`timescale 1ns/10ps
`default_nettype none

module opcode_decoder (
    input  wire cpu_ctrl_pkg::opcode_t opcode,
    output cpu_ctrl_pkg::instr_class_t instr_class,
    output cpu_ctrl_pkg::alu_op_t      alu_op,
    output cpu_ctrl_pkg::dest_t        dest,
    output cpu_ctrl_pkg::cond_t        cond
);

    import cpu_ctrl_pkg::*;

    typedef struct packed {
        instr_class_t cls;
        alu_op_t      op;
        dest_t        dst;
        cond_t        cnd;
    } dec_entry_t;

    dec_entry_t entry;

    // ==============================
    // Decode table
    // ==============================
    always_comb begin
        entry = '{CL_NOP, ALU_ADD, DEST_NONE, COND_ALWAYS};   // NOP and anything unknown
        case (opcode)
            // Loads and stores
            OPC_LDA_IMM: entry = '{CL_LOAD_IMM, ALU_ADD, DEST_ACC, COND_ALWAYS};
            OPC_LDX_IMM: entry = '{CL_LOAD_IMM, ALU_ADD, DEST_X, COND_ALWAYS};
            OPC_LDY_IMM: entry = '{CL_LOAD_IMM, ALU_ADD, DEST_Y, COND_ALWAYS};
            OPC_LDA_DIR: entry = '{CL_LOAD_DIR, ALU_ADD, DEST_ACC, COND_ALWAYS};
            OPC_STA_DIR: entry = '{CL_STORE_DIR, ALU_ADD, DEST_NONE, COND_ALWAYS};

            // Immediate operand ALU ops
            OPC_ADD_IMM: entry = '{CL_ALU_IMM, ALU_ADD, DEST_ACC, COND_ALWAYS};
            OPC_SUB_IMM: entry = '{CL_ALU_IMM, ALU_SUB, DEST_ACC, COND_ALWAYS};
            OPC_AND_IMM: entry = '{CL_ALU_IMM, ALU_AND, DEST_ACC, COND_ALWAYS};
            OPC_OR_IMM:  entry = '{CL_ALU_IMM, ALU_OR, DEST_ACC, COND_ALWAYS};
            OPC_XOR_IMM: entry = '{CL_ALU_IMM, ALU_XOR, DEST_ACC, COND_ALWAYS};
            OPC_CMP_IMM: entry = '{CL_ALU_IMM, ALU_CMP, DEST_NONE, COND_ALWAYS};

            // Implied ALU ops
            OPC_MUL:     entry = '{CL_ALU_IMPL, ALU_MUL, DEST_ACC, COND_ALWAYS};
            OPC_DIV:     entry = '{CL_ALU_IMPL, ALU_DIV, DEST_ACC, COND_ALWAYS};
            OPC_INC:     entry = '{CL_ALU_IMPL, ALU_INC, DEST_ACC, COND_ALWAYS};
            OPC_DEC:     entry = '{CL_ALU_IMPL, ALU_DEC, DEST_ACC, COND_ALWAYS};
            OPC_NOT:     entry = '{CL_ALU_IMPL, ALU_NOT, DEST_ACC, COND_ALWAYS};
            OPC_SHL:     entry = '{CL_ALU_IMPL, ALU_SHL, DEST_ACC, COND_ALWAYS};
            OPC_SHR:     entry = '{CL_ALU_IMPL, ALU_SHR, DEST_ACC, COND_ALWAYS};
            OPC_ROL:     entry = '{CL_ALU_IMPL, ALU_ROL, DEST_ACC, COND_ALWAYS};
            OPC_ROR:     entry = '{CL_ALU_IMPL, ALU_ROR, DEST_ACC, COND_ALWAYS};

            // Relative branches
            OPC_BEQ:     entry = '{CL_BRANCH, ALU_ADD, DEST_NONE, COND_Z};
            OPC_BNE:     entry = '{CL_BRANCH, ALU_ADD, DEST_NONE, COND_NZ};
            OPC_BMI:     entry = '{CL_BRANCH, ALU_ADD, DEST_NONE, COND_N};
            OPC_BPL:     entry = '{CL_BRANCH, ALU_ADD, DEST_NONE, COND_NN};
            OPC_BCS:     entry = '{CL_BRANCH, ALU_ADD, DEST_NONE, COND_C};
            OPC_BCC:     entry = '{CL_BRANCH, ALU_ADD, DEST_NONE, COND_NC};
            OPC_BRA:     entry = '{CL_BRANCH, ALU_ADD, DEST_NONE, COND_ALWAYS};

            OPC_JMP:     entry = '{CL_JUMP, ALU_ADD, DEST_NONE, COND_ALWAYS};
            default:     entry = '{CL_NOP, ALU_ADD, DEST_NONE, COND_ALWAYS};
        endcase
    end

    assign instr_class = entry.cls;
    assign alu_op      = entry.op;
    assign dest        = entry.dst;
    assign cond        = entry.cnd;

endmodule

`default_nettype wire

/* include/tb_ref_model.svh */
/*
 * Control unit testbench reference model
 * Expected strobes and PC per instruction, LCG and value check
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    logic [1:0]  wr_dest;      // 0 none, 1 acc, 2 x, 3 y
    logic        store;
    logic [15:0] store_addr;
    logic        dir_read;
    logic        alu_used;
    logic [3:0]  alu_op;
    logic        load;
    logic [15:0] target;
    logic [1:0]  incs;
    logic [15:0] final_pc;
} expect_t;

// ==============================
// Reference model
// ==============================
function automatic expect_t expect_instr(input logic [7:0] opc, input logic [7:0] opnd,
                                         input logic [7:0] flg, input logic [15:0] pc);
    expect_t     e;
    logic        take;
    logic [15:0] rel_tgt;
    e = '0;
    e.incs = 2'd2;
    e.final_pc = pc + 16'd2;
    rel_tgt = pc + 16'd2 + {{8{opnd[7]}}, opnd};
    take = 1'b0;
    case (opc)
        OPC_LDA_IMM: e.wr_dest = 2'd1;
        OPC_LDX_IMM: e.wr_dest = 2'd2;
        OPC_LDY_IMM: e.wr_dest = 2'd3;
        OPC_LDA_DIR: begin
            e.wr_dest = 2'd1;
            e.dir_read = 1'b1;
        end
        OPC_STA_DIR: begin
            e.store = 1'b1;
            e.store_addr = {8'h00, opnd};
        end
        OPC_ADD_IMM: e.alu_op = 4'h0;
        OPC_SUB_IMM: e.alu_op = 4'h1;
        OPC_AND_IMM: e.alu_op = 4'h4;
        OPC_OR_IMM:  e.alu_op = 4'h5;
        OPC_XOR_IMM: e.alu_op = 4'h6;
        OPC_CMP_IMM: e.alu_op = 4'hE;
        OPC_MUL:     e.alu_op = 4'h2;
        OPC_DIV:     e.alu_op = 4'h3;
        OPC_NOT:     e.alu_op = 4'h7;
        OPC_SHL:     e.alu_op = 4'h8;
        OPC_SHR:     e.alu_op = 4'h9;
        OPC_ROL:     e.alu_op = 4'hA;
        OPC_ROR:     e.alu_op = 4'hB;
        OPC_INC:     e.alu_op = 4'hC;
        OPC_DEC:     e.alu_op = 4'hD;
        OPC_BEQ:     take = flg[FLAG_Z];
        OPC_BNE:     take = !flg[FLAG_Z];
        OPC_BMI:     take = flg[FLAG_N];
        OPC_BPL:     take = !flg[FLAG_N];
        OPC_BCS:     take = flg[FLAG_C];
        OPC_BCC:     take = !flg[FLAG_C];
        OPC_BRA:     take = 1'b1;
        OPC_JMP: begin
            e.load = 1'b1;
            e.target = {8'h00, opnd};
            e.final_pc = e.target;
        end
        default: begin                   // NOP and unknown opcodes
            e.incs = 2'd1;
            e.final_pc = pc + 16'd1;
        end
    endcase
    case (opc)
        OPC_ADD_IMM, OPC_SUB_IMM, OPC_AND_IMM, OPC_OR_IMM, OPC_XOR_IMM, OPC_CMP_IMM: begin
            e.alu_used = 1'b1;
            e.wr_dest = (opc == OPC_CMP_IMM) ? 2'd0 : 2'd1;
        end
        OPC_MUL, OPC_DIV, OPC_NOT, OPC_SHL, OPC_SHR, OPC_ROL, OPC_ROR, OPC_INC, OPC_DEC: begin
            e.alu_used = 1'b1;
            e.wr_dest = 2'd1;
            e.incs = 2'd1;               // No operand byte
            e.final_pc = pc + 16'd1;
        end
        default: ;
    endcase
    if (take) begin
        e.load = 1'b1;
        e.target = rel_tgt;
        e.final_pc = rel_tgt;
    end
    return e;
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    end
endtask

`endif

/* tests/control_unit_tb.sv */
/*
 * Control unit testbench
 * Memory, PC and ALU models around the DUT, instruction runs with reference checks
 */
`timescale 1ns/10ps
`default_nettype none

module control_unit_tb;

    import cpu_ctrl_pkg::*;

    logic        clk;
    logic        reset;
    logic [7:0]  flags;
    logic        alu_done;
    logic [7:0]  data_bus;
    logic [15:0] pc_current;
    wire         acc_write, x_write, y_write, pc_inc, pc_load;
    wire         mem_read, mem_write, alu_start, done;
    wire  [15:0] mem_addr, pc_direct;
    alu_op_t     alu_operation;

    logic [7:0]  mem [256];
    logic [15:0] pc_reg;
    logic        rd_q;
    logic [7:0]  rd_addr_q;
    logic        alu_busy;
    logic [2:0]  alu_cnt;
    logic [2:0]  alu_delay;
    logic [7:0]  alu_opcs [15];
    logic [7:0]  br_opcs [8];
    int          errors;
    int          checks;
    logic        timed_out;
    logic [31:0] seed;

    `include "tb_ref_model.svh"

    control_unit uut (
        .clk           (clk),
        .reset         (reset),
        .flags         (flags),
        .alu_done      (alu_done),
        .data_bus      (data_bus),
        .pc_current    (pc_current),
        .acc_write     (acc_write),
        .x_write       (x_write),
        .y_write       (y_write),
        .pc_inc        (pc_inc),
        .pc_load       (pc_load),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .alu_operation (alu_operation),
        .alu_start     (alu_start),
        .mem_addr      (mem_addr),
        .pc_direct     (pc_direct),
        .done          (done)
    );

    always #20 clk = ~clk;

    // ==============================
    // Memory, PC and ALU models
    // ==============================
    always @(posedge clk) begin
        rd_q      <= mem_read;
        rd_addr_q <= mem_addr[7:0];
        if (pc_load) pc_reg <= pc_direct;
        else if (pc_inc) pc_reg <= pc_reg + 16'd1;
        if (alu_start) begin
            alu_busy <= 1'b1;
            alu_cnt  <= alu_delay;
        end else if (alu_busy && done) begin
            alu_busy <= 1'b0;
        end else if (alu_busy && alu_cnt != 3'd0) begin
            alu_cnt <= alu_cnt - 3'd1;
        end
    end

    always @(negedge clk) begin
        pc_current <= pc_reg;
        if (rd_q) data_bus <= mem[rd_addr_q];   // Byte appears after the read edge
        alu_done <= alu_busy && (alu_cnt == 3'd0);
    end

    // One instruction from the IDLE cycle up to done
    task automatic run_instr(input string name, input logic [7:0] opc,
                             input logic [7:0] opnd, input logic [7:0] flg);
        expect_t     e;
        int          n_acc, n_x, n_y, n_inc, n_load, n_wr, n_start, cyc;
        logic [15:0] start_pc, first_rd, last_rd, rd_at_acc, wr_addr, load_tgt;
        logic        seen_rd, got_done, early_acc;
        logic [3:0]  op_seen;
        if (!timed_out) begin
            n_acc = 0;
            n_x = 0;
            n_y = 0;
            n_inc = 0;
            n_load = 0;
            n_wr = 0;
            n_start = 0;
            cyc = 0;
            first_rd = '0;
            last_rd = '0;
            rd_at_acc = '0;
            wr_addr = '0;
            load_tgt = '0;
            seen_rd = 1'b0;
            got_done = 1'b0;
            early_acc = 1'b0;
            op_seen = '0;
            start_pc = pc_reg;
            mem[start_pc[7:0]] = opc;
            mem[start_pc[7:0] + 8'd1] = opnd;
            flags = flg;
            seed = lcg_next(seed);
            alu_delay = seed[26:24];
            e = expect_instr(opc, opnd, flg, start_pc);
            while (!got_done && cyc < 40) begin
                @(posedge clk);
                cyc++;
                if (acc_write) begin
                    n_acc++;
                    rd_at_acc = last_rd;       // Reads from earlier cycles only
                    if (e.alu_used && !alu_done) early_acc = 1'b1;
                end
                if (mem_read) begin
                    if (!seen_rd) first_rd = mem_addr;
                    seen_rd = 1'b1;
                    last_rd = mem_addr;
                end
                if (x_write) n_x++;
                if (y_write) n_y++;
                if (pc_inc) n_inc++;
                if (alu_start) begin
                    n_start++;
                    op_seen = alu_operation;
                end
                if (mem_write) begin
                    n_wr++;
                    wr_addr = mem_addr;
                end
                if (pc_load) begin
                    n_load++;
                    load_tgt = pc_direct;
                end
                if (done) got_done = 1'b1;
            end
            @(negedge clk);
            if (!got_done) begin
                $display("Timeout: %s never raised done within 40 cycles", name);
                timed_out = 1'b1;
            end else begin
                check_value({name, " fetch read"}, 32'd1, 32'(seen_rd));
                check_value({name, " fetch addr"}, 32'(start_pc), 32'(first_rd));
                check_value({name, " acc_write"}, (e.wr_dest == 2'd1) ? 1 : 0, n_acc);
                check_value({name, " x_write"}, (e.wr_dest == 2'd2) ? 1 : 0, n_x);
                check_value({name, " y_write"}, (e.wr_dest == 2'd3) ? 1 : 0, n_y);
                check_value({name, " pc_inc"}, 32'(e.incs), n_inc);
                check_value({name, " mem_write"}, 32'(e.store), n_wr);
                check_value({name, " pc_load"}, 32'(e.load), n_load);
                check_value({name, " alu_start"}, 32'(e.alu_used), n_start);
                check_value({name, " early acc_write"}, 32'd0, 32'(early_acc));
                check_value({name, " final pc"}, 32'(e.final_pc), 32'(pc_reg));
                if (e.store) check_value({name, " store addr"}, 32'(e.store_addr), 32'(wr_addr));
                if (e.dir_read) check_value({name, " read addr"}, {24'd0, opnd}, 32'(rd_at_acc));
                if (e.alu_used) check_value({name, " alu op"}, 32'(e.alu_op), 32'(op_seen));
                if (e.load) check_value({name, " pc_direct"}, 32'(e.target), 32'(load_tgt));
            end
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        int         i;
        int         idx;
        logic [7:0] opc;
        logic [7:0] flg;
        clk = 1'b0;
        reset = 1'b1;
        flags = 8'h00;
        alu_done <= 1'b0;
        data_bus <= 8'h00;
        pc_current <= 16'h0010;
        pc_reg <= 16'h0010;
        rd_q <= 1'b0;
        rd_addr_q <= 8'h00;
        alu_busy <= 1'b0;
        alu_cnt <= 3'd0;
        alu_delay = 3'd0;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        seed = 32'h5d33_4615;
        alu_opcs = '{OPC_ADD_IMM, OPC_SUB_IMM, OPC_AND_IMM, OPC_OR_IMM, OPC_XOR_IMM,
                     OPC_CMP_IMM, OPC_MUL, OPC_DIV, OPC_INC, OPC_DEC,
                     OPC_NOT, OPC_SHL, OPC_SHR, OPC_ROL, OPC_ROR};
        br_opcs = '{OPC_BEQ, OPC_BNE, OPC_BMI, OPC_BPL, OPC_BCS, OPC_BCC, OPC_BRA, OPC_JMP};
        for (i = 0; i < 256; i++) mem[i] = 8'(i) ^ 8'h5A;

        repeat (4) @(negedge clk);
        @(posedge clk);
        check_value("reset strobes", 32'd0, {23'd0, acc_write, x_write, y_write, pc_inc,
                    pc_load, mem_read, mem_write, alu_start, done});
        @(negedge clk);
        reset = 1'b0;

        run_instr("lda_imm", OPC_LDA_IMM, 8'h3C, 8'h00);
        run_instr("ldx_imm", OPC_LDX_IMM, 8'hA1, 8'h00);
        run_instr("ldy_imm", OPC_LDY_IMM, 8'h07, 8'h00);
        run_instr("sta_dir", OPC_STA_DIR, 8'hC4, 8'h00);
        run_instr("lda_dir", OPC_LDA_DIR, 8'hC4, 8'h00);

        for (i = 0; i < 24; i++) begin
            seed = lcg_next(seed);
            idx = int'(seed[23:16]) % 15;
            run_instr("alu", alu_opcs[idx], seed[31:24], 8'h00);
        end
        for (i = 0; i < 32; i++) begin
            seed = lcg_next(seed);
            opc = br_opcs[seed[18:16]];
            flg = {4'h0, seed[27:24]};
            seed = lcg_next(seed);
            run_instr("branch", opc, seed[31:24], flg);
        end

        run_instr("nop", OPC_NOP, 8'h11, 8'h00);
        run_instr("unused_70", 8'h70, 8'h22, 8'h0F);
        run_instr("unused_ff", 8'hFF, 8'h33, 8'h00);

        $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
